// File: common/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcode in bits 31:27
    typedef enum logic [4:0] {
        op_rtype = 5'd0,
        op_j     = 5'd1,
        op_bne   = 5'd2,
        op_jal   = 5'd3,
        op_jr    = 5'd4,
        op_addi  = 5'd5,
        op_blt   = 5'd6,
        op_sw    = 5'd7,
        op_lw    = 5'd8
    } opcode_t;

    // R-type function field in bits 6:2
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [4:0] shamt;
        alu_op_t    alu_op;
        logic [1:0] spare;
    } r_view_t;

    typedef struct packed {
        opcode_t            opcode;
        reg_idx_t           rd;
        reg_idx_t           rs;
        logic signed [16:0] imm;
    } i_view_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [26:0] target;
    } j_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } insn_t;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_t;

    localparam reg_idx_t reg_zero = 5'd0;
    localparam reg_idx_t reg_ra   = 5'd31;

    // add r0, r0, r0 doubles as the pipeline bubble
    localparam word_t insn_nop = 32'd0;

endpackage

// File: compile.f
common/isa_pkg.sv
logic/alu.sv
logic/regfile.sv
core/fetch_decode.sv
core/execute_stage.sv
core/mem_wb_stage.sv
core/hazard_unit.sv
core/cpu_top.sv
tb/tb_memory.sv
tb/cpu_tb.sv

// File: core/cpu_top.sv
module cpu_top import isa_pkg::*; #(
    parameter int    pc_width = 32,
    parameter word_t reset_pc = '0
) (
    input  logic  clock,
    input  logic  rst_n,
    output word_t address_imem,
    input  word_t q_imem,
    output word_t address_dmem,
    output word_t data_dmem,
    output logic  wren,
    input  word_t q_dmem
);

    reg_idx_t rs_addr;
    reg_idx_t rt_addr;
    word_t    rs_data;
    word_t    rt_data;
    insn_t    fd_insn;
    insn_t    dx_insn;
    word_t    dx_a;
    word_t    dx_b;
    word_t    dx_pc;
    logic     redirect;
    word_t    redirect_pc;
    insn_t    xm_insn;
    word_t    xm_result;
    word_t    xm_store;
    insn_t    mw_insn;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     fwd_store;
    logic     stall;

    fetch_decode #(
        .pc_width (pc_width),
        .reset_pc (reset_pc)
    ) fetch_decode_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .q_imem       (q_imem),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .fd_insn      (fd_insn),
        .dx_insn      (dx_insn),
        .dx_a         (dx_a),
        .dx_b         (dx_b),
        .dx_pc        (dx_pc)
    );

    execute_stage #(
        .pc_width (pc_width)
    ) execute_stage_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .dx_insn     (dx_insn),
        .dx_a        (dx_a),
        .dx_b        (dx_b),
        .dx_pc       (dx_pc),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm_insn     (xm_insn),
        .xm_result   (xm_result),
        .xm_store    (xm_store)
    );

    mem_wb_stage mem_wb_stage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .xm_insn      (xm_insn),
        .xm_result    (xm_result),
        .xm_store     (xm_store),
        .q_dmem       (q_dmem),
        .fwd_store    (fwd_store),
        .address_dmem (address_dmem),
        .data_dmem    (data_dmem),
        .wren         (wren),
        .mw_insn      (mw_insn),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data)
    );

    hazard_unit hazard_unit_i (
        .fd_insn   (fd_insn),
        .dx_insn   (dx_insn),
        .xm_insn   (xm_insn),
        .mw_insn   (mw_insn),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .fwd_store (fwd_store),
        .stall     (stall)
    );

    regfile regfile_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

// File: core/execute_stage.sv
module execute_stage import isa_pkg::*; #(
    parameter int pc_width = 32
) (
    input  logic     clock,
    input  logic     rst_n,
    input  insn_t    dx_insn,
    input  word_t    dx_a,
    input  word_t    dx_b,
    input  word_t    dx_pc,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    wb_data,
    output logic     redirect,
    output word_t    redirect_pc,
    output insn_t    xm_insn,
    output word_t    xm_result,
    output word_t    xm_store
);

    opcode_t op;
    alu_op_t alu_fn;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_result;
    word_t   imm;
    word_t   link_pc;
    word_t   target;
    logic    use_imm;
    logic    not_equal;
    logic    less_than;
    logic    taken;
    logic    jump;
    insn_t   x_insn;
    word_t   x_result;

    function automatic word_t bypass(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                     word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Keep only the implemented program-counter bits
    function automatic word_t fit_pc(word_t addr);
        return word_t'(addr[pc_width-1:0]);
    endfunction

    assign op   = dx_insn.r.opcode;
    assign op_a = bypass(fwd_a, dx_a, xm_result, wb_data);
    assign op_b = bypass(fwd_b, dx_b, xm_result, wb_data);
    assign imm  = {{15{dx_insn.i.imm[16]}}, dx_insn.i.imm};

    assign use_imm = op inside {op_addi, op_lw, op_sw};
    assign alu_b   = use_imm ? imm : op_b;
    assign alu_fn  = (op == op_rtype) ? dx_insn.r.alu_op : alu_add;

    alu alu_i (
        .a         (op_a),
        .b         (alu_b),
        .op        (alu_fn),
        .shamt     (dx_insn.r.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // A holds rs and B holds rd, so blt wants B < A
    assign taken = (op == op_bne && not_equal) ||
                   (op == op_blt && !less_than && not_equal);
    assign jump  = op inside {op_j, op_jal, op_jr};

    assign link_pc = fit_pc(dx_pc + 32'd1);

    always_comb begin
        if (taken) begin
            target = link_pc + imm;
        end else if (op == op_jr) begin
            target = op_b;
        end else begin
            target = {5'd0, dx_insn.j.target};
        end
    end

    assign redirect    = taken || jump;
    assign redirect_pc = fit_pc(target);

    // jal becomes a plain write of the return address to r31
    always_comb begin
        x_insn   = dx_insn;
        x_result = alu_result;
        if (op == op_jal) begin
            x_insn.r.rd = reg_ra;
            x_result    = link_pc;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm_insn <= insn_nop;
        end else begin
            xm_insn <= x_insn;
        end
    end

    // Store data is the bypassed rd value, not the ALU operand
    always_ff @(posedge clock) begin
        xm_result <= x_result;
        xm_store  <= op_b;
    end

endmodule

// File: core/fetch_decode.sv
module fetch_decode import isa_pkg::*; #(
    parameter int    pc_width = 32,
    parameter word_t reset_pc = '0
) (
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    q_imem,
    input  logic     stall,
    input  logic     redirect,
    input  word_t    redirect_pc,
    output word_t    address_imem,
    output reg_idx_t rs_addr,
    output reg_idx_t rt_addr,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output insn_t    fd_insn,
    output insn_t    dx_insn,
    output word_t    dx_a,
    output word_t    dx_b,
    output word_t    dx_pc
);

    logic [pc_width-1:0] pc;
    logic [pc_width-1:0] fd_pc;

    assign address_imem = word_t'(pc);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc[pc_width-1:0];
        end else if (redirect) begin
            pc <= redirect_pc[pc_width-1:0];
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // FD register, squashed when execute redirects fetch
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fd_insn <= insn_nop;
        end else if (redirect) begin
            fd_insn <= insn_nop;
        end else if (!stall) begin
            fd_insn <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc <= pc;
        end
    end

    // Second port reads rd for instructions that use it as a source
    assign rs_addr = fd_insn.r.rs;
    assign rt_addr = (fd_insn.r.opcode inside {op_sw, op_bne, op_blt, op_jr}) ?
                     fd_insn.r.rd : fd_insn.r.rt;

    // DX register, a bubble goes in on a load-use stall or a redirect
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx_insn <= insn_nop;
        end else if (redirect || stall) begin
            dx_insn <= insn_nop;
        end else begin
            dx_insn <= fd_insn;
        end
    end

    always_ff @(posedge clock) begin
        dx_a  <= rs_data;
        dx_b  <= rt_data;
        dx_pc <= word_t'(fd_pc);
    end

    // A load in DX is never a branch or jump at the same time
    stall_redirect_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n) !(stall && redirect)
    );

endmodule

// File: core/hazard_unit.sv
module hazard_unit import isa_pkg::*; (
    input  insn_t    fd_insn,
    input  insn_t    dx_insn,
    input  insn_t    xm_insn,
    input  insn_t    mw_insn,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output logic     fwd_store,
    output logic     stall
);

    logic mem_ok;
    logic wb_ok;
    logic dx_load;
    logic fd_rs_hit;
    logic fd_second_hit;

    function automatic logic writes_rd(insn_t insn);
        return (insn.r.opcode inside {op_rtype, op_addi, op_lw, op_jal}) &&
               (insn.r.rd != reg_zero);
    endfunction

    function automatic logic reads_rs(insn_t insn);
        return insn.r.opcode inside {op_rtype, op_addi, op_lw, op_sw, op_bne, op_blt};
    endfunction

    function automatic logic reads_second(insn_t insn);
        return insn.r.opcode inside {op_rtype, op_sw, op_bne, op_blt, op_jr};
    endfunction

    function automatic reg_idx_t second_reg(insn_t insn);
        return (insn.r.opcode == op_rtype) ? insn.r.rt : insn.r.rd;
    endfunction

    // Memory stage takes priority over writeback
    function automatic fwd_sel_t pick(logic used, reg_idx_t src, logic m_ok, reg_idx_t m_rd,
                                      logic w_ok, reg_idx_t w_rd);
        if (used && m_ok && m_rd == src) begin
            return fwd_mem;
        end else if (used && w_ok && w_rd == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    // Load data is not ready in memory, the store-data path picks it up later
    assign mem_ok = writes_rd(xm_insn) && (xm_insn.r.opcode != op_lw);
    assign wb_ok  = writes_rd(mw_insn);

    assign fwd_a = pick(reads_rs(dx_insn), dx_insn.r.rs,
                        mem_ok, xm_insn.r.rd, wb_ok, mw_insn.r.rd);
    assign fwd_b = pick(reads_second(dx_insn), second_reg(dx_insn),
                        mem_ok, xm_insn.r.rd, wb_ok, mw_insn.r.rd);

    assign fwd_store = (xm_insn.r.opcode == op_sw) && wb_ok &&
                       (mw_insn.r.rd == xm_insn.r.rd);

    // Store data register is excluded from the stall
    assign dx_load       = (dx_insn.r.opcode == op_lw) && (dx_insn.r.rd != reg_zero);
    assign fd_rs_hit     = reads_rs(fd_insn) && (fd_insn.r.rs == dx_insn.r.rd);
    assign fd_second_hit = (fd_insn.r.opcode inside {op_rtype, op_bne, op_blt, op_jr}) &&
                           (second_reg(fd_insn) == dx_insn.r.rd);
    assign stall         = dx_load && (fd_rs_hit || fd_second_hit);

endmodule

// File: core/mem_wb_stage.sv
module mem_wb_stage import isa_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  insn_t    xm_insn,
    input  word_t    xm_result,
    input  word_t    xm_store,
    input  word_t    q_dmem,
    input  logic     fwd_store,
    output word_t    address_dmem,
    output word_t    data_dmem,
    output logic     wren,
    output insn_t    mw_insn,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    word_t mw_result;
    word_t mw_load;

    assign address_dmem = xm_result;
    assign data_dmem    = fwd_store ? wb_data : xm_store;
    assign wren         = (xm_insn.r.opcode == op_sw);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_insn <= insn_nop;
        end else begin
            mw_insn <= xm_insn;
        end
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load   <= q_dmem;
    end

    // Writes to r0 are dropped here
    assign wb_reg  = mw_insn.r.rd;
    assign wb_en   = (mw_insn.r.opcode inside {op_rtype, op_addi, op_lw, op_jal}) &&
                     (mw_insn.r.rd != reg_zero);
    assign wb_data = (mw_insn.r.opcode == op_lw) ? mw_load : mw_result;

endmodule

// File: logic/alu.sv
module alu import isa_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_t    op,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       not_equal,
    output logic       less_than
);

    always_comb begin
        case (op)
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            default: result = a + b;
        endcase
    end

    // Flags compare the operands as signed words
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

// File: logic/regfile.sv
module regfile import isa_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data,
    input  reg_idx_t rs_addr,
    input  reg_idx_t rt_addr,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [1:31];

    always_ff @(posedge clock) begin
        if (wb_en && wb_reg != reg_zero) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Same-cycle write is passed straight to decode
    assign rs_data = (rs_addr == reg_zero) ? '0 :
                     (wb_en && wb_reg == rs_addr) ? wb_data : regs[rs_addr];
    assign rt_data = (rt_addr == reg_zero) ? '0 :
                     (wb_en && wb_reg == rt_addr) ? wb_data : regs[rt_addr];

    // Writeback never enables a write to register 0
    no_zero_write: assert property (
        @(posedge clock) disable iff (!rst_n) !(wb_en && wb_reg == reg_zero)
    );

endmodule

// File: tb/cpu_tb.sv
module cpu_tb import isa_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests      = 5;
    localparam int run_cycles     = 80;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = num_tests * (run_cycles + reset_cycles) + 100;

    logic  clock;
    logic  rst_n;
    word_t address_imem;
    word_t q_imem;
    word_t address_dmem;
    word_t data_dmem;
    logic  wren;
    word_t q_dmem;

    logic [15:0] lfsr_state;
    int          pc_fill;
    int          exp_count;
    word_t       exp_addr [0:31];
    word_t       exp_data [0:31];
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;

    cpu_top #(
        .pc_width (32),
        .reset_pc (32'd0)
    ) cpu_top_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data_dmem    (data_dmem),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    tb_memory memory_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data_dmem    (data_dmem),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // 16-bit Galois LFSR, one step per bit handed out
    function automatic word_t take_bits(input int n);
        word_t value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic word_t sext17(input logic [16:0] v);
        return {{15{v[16]}}, v};
    endfunction

    function automatic word_t r_insn(input alu_op_t fn, input reg_idx_t rd, input reg_idx_t rs,
                                     input reg_idx_t rt, input logic [4:0] shamt);
        return {op_rtype, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic word_t i_insn(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs,
                                     input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t j_insn(input opcode_t op, input logic [26:0] target);
        return {op, target};
    endfunction

    // bne compares rd against rs, blt asks for rd < rs as signed words
    function automatic logic branch_taken(input opcode_t kind, input word_t rd_val,
                                          input word_t rs_val);
        if (kind == op_bne) begin
            return rd_val != rs_val;
        end
        return $signed(rd_val) < $signed(rs_val);
    endfunction

    task automatic start_program();
        @(posedge clock);
        #2;
        rst_n = 1'b0;
        memory_i.clear_program();
        pc_fill = 0;
        exp_count = 0;
    endtask

    task automatic emit(input word_t insn);
        memory_i.write_insn(pc_fill, insn);
        pc_fill++;
    endtask

    task automatic halt();
        emit(j_insn(op_j, 27'(pc_fill)));
    endtask

    task automatic store_word(input reg_idx_t data_reg, input logic [16:0] addr);
        emit(i_insn(op_sw, data_reg, reg_zero, addr));
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    task automatic run_program();
        repeat (reset_cycles) @(posedge clock);
        #2;
        rst_n = 1'b1;
        repeat (run_cycles) @(posedge clock);
        #2;
    endtask

    task automatic check_log(input string name);
        int seen;
        int limit;
        seen = memory_i.log_count;
        if (seen != exp_count) begin
            $display("Test %s: the program made %0d stores but %0d were expected",
                     name, seen, exp_count);
            error_count++;
        end
        limit = (seen < exp_count) ? seen : exp_count;
        for (int k = 0; k < limit; k++) begin
            if (memory_i.log_addr[k] !== exp_addr[k] || memory_i.log_data[k] !== exp_data[k]) begin
                $display("Fail at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                         $time, name, k, memory_i.log_data[k], memory_i.log_addr[k],
                         exp_data[k], exp_addr[k]);
                error_count++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        check_log(name);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Skips two marker stores, which only land when the branch falls through
    task automatic branch_site(input opcode_t kind, input reg_idx_t rd, input word_t rd_val,
                               input reg_idx_t rs, input word_t rs_val,
                               input reg_idx_t marker_reg, input word_t marker_val,
                               input int addr);
        emit(i_insn(kind, rd, rs, 17'd2));
        store_word(marker_reg, 17'(addr));
        store_word(marker_reg, 17'(addr + 1));
        if (!branch_taken(kind, rd_val, rs_val)) begin
            expect_store(addr, marker_val);
            expect_store(addr + 1, marker_val);
        end
    endtask

    task automatic arith_chain();
        int          errors_before;
        logic [16:0] imm [0:2];
        logic [4:0]  sh_left;
        logic [4:0]  sh_right;
        word_t       v [1:9];
        errors_before = error_count;
        start_program();
        for (int k = 0; k < 3; k++) begin
            imm[k] = 17'(take_bits(17));
        end
        sh_left = 5'(take_bits(5));
        sh_right = 5'(take_bits(5));
        emit(i_insn(op_addi, 1, 0, imm[0]));
        emit(i_insn(op_addi, 2, 1, imm[1]));
        emit(i_insn(op_addi, 3, 2, imm[2]));
        emit(r_insn(alu_add, 4, 3, 2, 0));
        emit(r_insn(alu_sub, 5, 4, 1, 0));
        emit(r_insn(alu_and, 6, 5, 3, 0));
        emit(r_insn(alu_or, 7, 6, 2, 0));
        emit(r_insn(alu_sll, 8, 7, 0, sh_left));
        emit(r_insn(alu_sra, 9, 8, 0, sh_right));
        v[1] = sext17(imm[0]);
        v[2] = v[1] + sext17(imm[1]);
        v[3] = v[2] + sext17(imm[2]);
        v[4] = v[3] + v[2];
        v[5] = v[4] - v[1];
        v[6] = v[5] & v[3];
        v[7] = v[6] | v[2];
        v[8] = v[7] << sh_left;
        v[9] = word_t'($signed(v[8]) >>> sh_right);
        // Newest result first, so the first stores need bypassed data
        for (int k = 9; k >= 1; k--) begin
            store_word(5'(k), 17'(100 + k));
            expect_store(100 + k, v[k]);
        end
        halt();
        run_program();
        finish_test("arithmetic", errors_before);
    endtask

    task automatic load_use_stall();
        int          errors_before;
        logic [16:0] imm_v;
        logic [16:0] imm_w;
        word_t       v;
        word_t       w;
        errors_before = error_count;
        start_program();
        imm_v = 17'(take_bits(17));
        imm_w = 17'(take_bits(17));
        v = sext17(imm_v);
        w = sext17(imm_w);
        emit(i_insn(op_addi, 1, 0, imm_v));
        emit(i_insn(op_addi, 2, 0, imm_w));
        store_word(1, 17'd120);
        expect_store(120, v);
        emit(i_insn(op_lw, 3, 0, 17'd120));
        emit(r_insn(alu_add, 4, 3, 2, 0));
        store_word(4, 17'd121);
        expect_store(121, v + w);
        emit(i_insn(op_lw, 5, 0, 17'd120));
        store_word(5, 17'd122);
        expect_store(122, v);
        // Loaded value used at once as a store base
        emit(i_insn(op_lw, 7, 0, 17'd121));
        emit(i_insn(op_sw, 5, 7, 17'd0));
        expect_store(v + w, v);
        halt();
        run_program();
        finish_test("load-use", errors_before);
    endtask

    task automatic branch_paths();
        int          errors_before;
        logic [16:0] m_imm [0:5];
        logic [16:0] x;
        logic [16:0] d;
        word_t       r1_val;
        word_t       r2_val;
        errors_before = error_count;
        start_program();
        for (int k = 0; k < 6; k++) begin
            m_imm[k] = 17'(take_bits(16));
            emit(i_insn(op_addi, 5'(11 + k), 0, m_imm[k]));
        end
        x = 17'(take_bits(17));
        d = 17'(take_bits(8)) + 17'd1;
        r1_val = sext17(x);
        r2_val = r1_val + sext17(d);
        emit(i_insn(op_addi, 1, 0, x));
        emit(i_insn(op_addi, 2, 1, d));
        branch_site(op_bne, 1, r1_val, 2, r2_val, 11, sext17(m_imm[0]), 140);
        branch_site(op_bne, 1, r1_val, 1, r1_val, 12, sext17(m_imm[1]), 142);
        branch_site(op_blt, 1, r1_val, 2, r2_val, 13, sext17(m_imm[2]), 144);
        branch_site(op_blt, 2, r2_val, 1, r1_val, 14, sext17(m_imm[3]), 146);
        branch_site(op_blt, 1, r1_val, 1, r1_val, 15, sext17(m_imm[4]), 148);
        branch_site(op_bne, 2, r2_val, 1, r1_val, 16, sext17(m_imm[5]), 150);
        halt();
        run_program();
        finish_test("branches", errors_before);
    endtask

    task automatic jump_paths();
        int          errors_before;
        int          jal_addr;
        logic [16:0] m_skip;
        logic [16:0] m_keep;
        errors_before = error_count;
        start_program();
        m_skip = 17'(take_bits(16));
        m_keep = 17'(take_bits(16));
        emit(i_insn(op_addi, 1, 0, m_skip));
        emit(i_insn(op_addi, 2, 0, m_keep));
        // jal to a routine six words on, which stores r31 and returns
        jal_addr = pc_fill;
        emit(j_insn(op_jal, 27'(jal_addr + 6)));
        store_word(2, 17'd150);
        emit(j_insn(op_j, 27'(jal_addr + 4)));
        store_word(1, 17'd151);
        store_word(2, 17'd152);
        halt();
        store_word(reg_ra, 17'd153);
        emit(i_insn(op_jr, reg_ra, 0, 17'd0));
        expect_store(153, jal_addr + 1);
        expect_store(150, sext17(m_keep));
        expect_store(152, sext17(m_keep));
        run_program();
        finish_test("jumps", errors_before);
    endtask

    task automatic zero_register();
        int          errors_before;
        logic [16:0] imm;
        errors_before = error_count;
        start_program();
        imm = 17'(take_bits(17)) | 17'd1;
        emit(i_insn(op_addi, 0, 0, imm));
        store_word(0, 17'd160);
        expect_store(160, 32'd0);
        emit(i_insn(op_addi, 1, 0, imm));
        emit(r_insn(alu_add, 0, 1, 1, 0));
        store_word(0, 17'd161);
        expect_store(161, 32'd0);
        emit(r_insn(alu_add, 2, 0, 1, 0));
        store_word(2, 17'd162);
        expect_store(162, sext17(imm));
        halt();
        run_program();
        finish_test("register zero", errors_before);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        lfsr_state = 16'd27554;
        pc_fill = 0;
        exp_count = 0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        arith_chain();
        load_use_stall();
        branch_paths();
        jump_paths();
        zero_register();
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tb/tb_memory.sv
module tb_memory import isa_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  word_t address_imem,
    output word_t q_imem,
    input  word_t address_dmem,
    input  word_t data_dmem,
    input  logic  wren,
    output word_t q_dmem
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int depth     = 256;
    localparam int log_depth = 64;

    word_t imem [0:depth-1];
    word_t dmem [0:depth-1];
    word_t log_addr [0:log_depth-1];
    word_t log_data [0:log_depth-1];
    int    log_count;

    // Every unused word is a jump to itself
    task automatic clear_program();
        for (int a = 0; a < depth; a++) begin
            imem[a] = {op_j, 27'(a)};
        end
    endtask

    task automatic write_insn(input int addr, input word_t insn);
        imem[addr % depth] = insn;
    endtask

    initial begin
        clear_program();
    end

    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Data memory refills and the store log empties while reset is low
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            log_count <= 0;
            for (int a = 0; a < depth; a++) begin
                dmem[a] <= 32'hc0de_0000 | word_t'(a);
            end
        end else if (wren) begin
            dmem[address_dmem[7:0]] <= data_dmem;
            if (log_count < log_depth) begin
                log_addr[log_count] <= address_dmem;
                log_data[log_count] <= data_dmem;
            end
            log_count <= log_count + 1;
        end
    end

endmodule
